// ==== logic/cps_bus_pkg.sv ====
package cps_bus_pkg;

    // one CPU strobe as seen on the bus
    // dsn is active low per byte lane, dsn[1] guards the upper byte
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [5:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] data;
    } bus_req_t;

    // registered access handed to one register window
    typedef struct packed {
        logic        valid;
        logic        wr;
        logic [4:0]  ofs;
        logic [1:0]  dsn;
        logic [15:0] data;
    } reg_access_t;

    // word address bit that selects the configurable window
    localparam int unsigned WINDOW_BIT = 5;

endpackage

// ==== logic/cps_video_pkg.sv ====
package cps_video_pkg;

    localparam int unsigned CFG_BYTES = 16;

    // slots of the configuration string
    // the first byte downloaded ends up in slot 15
    localparam logic [3:0] CFG_ID_ADDR  = 4'd0;
    localparam logic [3:0] CFG_ID_VALUE = 4'd1;
    localparam logic [3:0] CFG_MULT1    = 4'd2;
    localparam logic [3:0] CFG_MULT2    = 4'd3;
    localparam logic [3:0] CFG_RSLT0    = 4'd4;
    localparam logic [3:0] CFG_RSLT1    = 4'd5;
    localparam logic [3:0] CFG_LAYER    = 4'd6;
    localparam logic [3:0] CFG_PRIO0    = 4'd7;
    localparam logic [3:0] CFG_PRIO1    = 4'd8;
    localparam logic [3:0] CFG_PRIO2    = 4'd9;
    localparam logic [3:0] CFG_PRIO3    = 4'd10;
    localparam logic [3:0] CFG_PAL_PAGE = 4'd11;
    localparam logic [3:0] CFG_MASK0    = 4'd12;
    localparam logic [3:0] CFG_MASK1    = 4'd13;
    localparam logic [3:0] CFG_MASK2    = 4'd14;
    localparam logic [3:0] CFG_MASK3    = 4'd15;

    // word offsets in the fixed window
    localparam logic [4:0] A_OFS_OBJ_BASE  = 5'd0;
    localparam logic [4:0] A_OFS_SCR1_BASE = 5'd1;
    localparam logic [4:0] A_OFS_SCR2_BASE = 5'd2;
    localparam logic [4:0] A_OFS_SCR3_BASE = 5'd3;
    localparam logic [4:0] A_OFS_ROW_BASE  = 5'd4;
    localparam logic [4:0] A_OFS_PAL_BASE  = 5'd5;
    localparam logic [4:0] A_OFS_HPOS1     = 5'd6;
    localparam logic [4:0] A_OFS_VPOS1     = 5'd7;
    localparam logic [4:0] A_OFS_HPOS2     = 5'd8;
    localparam logic [4:0] A_OFS_VPOS2     = 5'd9;
    localparam logic [4:0] A_OFS_HPOS3     = 5'd10;
    localparam logic [4:0] A_OFS_VPOS3     = 5'd11;
    localparam logic [4:0] A_OFS_PPU_CTRL  = 5'd17;

    // draw order 3,2,1,0 in bits 13:6 and all four layers enabled in bits 4:1
    localparam logic [15:0] LAYER_CTRL_RESET =
        {2'b00, 2'b00, 2'b01, 2'b10, 2'b11, 1'b0, 4'b1111, 1'b0};

    localparam logic [15:0] NO_DATA = 16'hffff;

    typedef struct packed {
        logic [15:0] obj_base;
        logic [15:0] scr1_base;
        logic [15:0] scr2_base;
        logic [15:0] scr3_base;
        logic [15:0] row_base;
        logic [15:0] pal_base;
        logic [15:0] hpos1;
        logic [15:0] vpos1;
        logic [15:0] hpos2;
        logic [15:0] vpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos3;
        logic [15:0] ppu_ctrl;
    } a_regs_t;

    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [5:0]  pal_page_en;
        logic [7:0]  layer_mask0;
        logic [7:0]  layer_mask1;
        logic [7:0]  layer_mask2;
        logic [7:0]  layer_mask3;
    } b_regs_t;

    // what the renderer works from during one frame
    typedef struct packed {
        a_regs_t         a;
        b_regs_t         b;
        logic [3:0][1:0] draw_order;
        logic [3:0]      layer_en;
    } frame_cfg_t;

endpackage

// ==== logic/cps_bus_decode.sv ====
`timescale 1ns/1ns

module cps_bus_decode (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  cps_bus_pkg::bus_req_t    bus_req,
    output cps_bus_pkg::reg_access_t a_acc,
    output cps_bus_pkg::reg_access_t b_acc
);

    logic        a_valid;
    logic        b_valid;
    logic        wr_q;
    logic [4:0]  ofs_q;
    logic [1:0]  dsn_q;
    logic [15:0] data_q;
    logic        in_b;

    assign in_b = bus_req.addr[cps_bus_pkg::WINDOW_BIT];

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            a_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            // nothing answers a read in the fixed window so it stops here
            a_valid <= bus_req.wr && !in_b;
            b_valid <= (bus_req.wr || bus_req.rd) && in_b;
        end
    end

    // payload is shared by both windows, only the valid bits steer it
    always_ff @(posedge clk) begin
        wr_q   <= bus_req.wr;
        ofs_q  <= bus_req.addr[4:0];
        dsn_q  <= bus_req.dsn;
        data_q <= bus_req.data;
    end

    assign a_acc = '{valid: a_valid, wr: wr_q, ofs: ofs_q, dsn: dsn_q, data: data_q};
    assign b_acc = '{valid: b_valid, wr: wr_q, ofs: ofs_q, dsn: dsn_q, data: data_q};

    strobe_kind: assert property (@(posedge clk) disable iff (reg_rst)
        !(bus_req.wr && bus_req.rd))
        else $error("bus strobe with both write and read set");

    one_window: assert property (@(posedge clk) disable iff (reg_rst)
        !(a_acc.valid && b_acc.valid))
        else $error("access routed to both register windows");

endmodule

// ==== logic/cps_a_regs.sv ====
`timescale 1ns/1ns

module cps_a_regs (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  cps_bus_pkg::reg_access_t acc,
    output cps_video_pkg::a_regs_t   live,
    output logic                     pal_copy
);

    logic        wr_en;
    logic        copy_pending;
    logic [15:0] wdata;

    // byte-lane merge, a low dsn bit lets that byte through
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_word,
        input logic [15:0] new_word,
        input logic [1:0]  dsn
    );
        logic [15:0] merged;
        merged[15:8] = dsn[1] ? old_word[15:8] : new_word[15:8];
        merged[7:0]  = dsn[0] ? old_word[7:0]  : new_word[7:0];
        return merged;
    endfunction

    assign wr_en = acc.valid && acc.wr;

    // current contents of the addressed word merged with the new data
    always_comb begin
        case (acc.ofs)
            cps_video_pkg::A_OFS_OBJ_BASE:  wdata = live.obj_base;
            cps_video_pkg::A_OFS_SCR1_BASE: wdata = live.scr1_base;
            cps_video_pkg::A_OFS_SCR2_BASE: wdata = live.scr2_base;
            cps_video_pkg::A_OFS_SCR3_BASE: wdata = live.scr3_base;
            cps_video_pkg::A_OFS_ROW_BASE:  wdata = live.row_base;
            cps_video_pkg::A_OFS_PAL_BASE:  wdata = live.pal_base;
            cps_video_pkg::A_OFS_HPOS1:     wdata = live.hpos1;
            cps_video_pkg::A_OFS_VPOS1:     wdata = live.vpos1;
            cps_video_pkg::A_OFS_HPOS2:     wdata = live.hpos2;
            cps_video_pkg::A_OFS_VPOS2:     wdata = live.vpos2;
            cps_video_pkg::A_OFS_HPOS3:     wdata = live.hpos3;
            cps_video_pkg::A_OFS_VPOS3:     wdata = live.vpos3;
            cps_video_pkg::A_OFS_PPU_CTRL:  wdata = live.ppu_ctrl;
            default:                        wdata = '0;
        endcase
        wdata = lane_merge(wdata, acc.data, acc.dsn);
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            live         <= '0;
            copy_pending <= 1'b0;
            pal_copy     <= 1'b0;
        end else begin
            // the copy waits for a quiet bus cycle
            // a base written in two halves is then complete
            pal_copy <= 1'b0;
            if (copy_pending && !acc.valid) begin
                pal_copy     <= 1'b1;
                copy_pending <= 1'b0;
            end
            if (wr_en) begin
                case (acc.ofs)
                    cps_video_pkg::A_OFS_OBJ_BASE:  live.obj_base  <= wdata;
                    cps_video_pkg::A_OFS_SCR1_BASE: live.scr1_base <= wdata;
                    cps_video_pkg::A_OFS_SCR2_BASE: live.scr2_base <= wdata;
                    cps_video_pkg::A_OFS_SCR3_BASE: live.scr3_base <= wdata;
                    cps_video_pkg::A_OFS_ROW_BASE:  live.row_base  <= wdata;
                    cps_video_pkg::A_OFS_PAL_BASE: begin
                        live.pal_base <= wdata;
                        copy_pending  <= 1'b1;
                    end
                    cps_video_pkg::A_OFS_HPOS1:     live.hpos1     <= wdata;
                    cps_video_pkg::A_OFS_VPOS1:     live.vpos1     <= wdata;
                    cps_video_pkg::A_OFS_HPOS2:     live.hpos2     <= wdata;
                    cps_video_pkg::A_OFS_VPOS2:     live.vpos2     <= wdata;
                    cps_video_pkg::A_OFS_HPOS3:     live.hpos3     <= wdata;
                    cps_video_pkg::A_OFS_VPOS3:     live.vpos3     <= wdata;
                    cps_video_pkg::A_OFS_PPU_CTRL:  live.ppu_ctrl  <= wdata;
                    default: ;
                endcase
            end
        end
    end

    copy_single: assert property (@(posedge clk) disable iff (reg_rst)
        pal_copy |=> !pal_copy)
        else $error("pal_copy held for more than one cycle");

endmodule

// ==== logic/cps_b_regs.sv ====
`timescale 1ns/1ns

module cps_b_regs (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  cps_bus_pkg::reg_access_t acc,
    input  logic                     cfg_we,
    input  logic [7:0]               cfg_data,
    output cps_video_pkg::b_regs_t   live,
    output logic                     rd_valid,
    output logic [15:0]              rd_data
);

    // per-game string, powers up cleared and survives reset
    logic [cps_video_pkg::CFG_BYTES-1:0][7:0] cfg = '0;

    logic [7:0]  id_byte;
    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [31:0] product;
    logic [15:0] layer_ctrl;
    logic [15:0] prio0;
    logic [15:0] prio1;
    logic [15:0] prio2;
    logic [15:0] prio3;
    logic [5:0]  pal_page_en;
    logic [15:0] rd_mux;
    logic        wr_word;
    logic        rd_req;

    logic hit_id;
    logic hit_mult1;
    logic hit_mult2;
    logic hit_rslt0;
    logic hit_rslt1;
    logic hit_layer;
    logic hit_prio0;
    logic hit_prio1;
    logic hit_prio2;
    logic hit_prio3;
    logic hit_pal_page;

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            cfg <= {cfg[cps_video_pkg::CFG_BYTES-2:0], cfg_data};
        end
    end

    // address bytes are byte addresses, bits 5:1 give the word offset
    assign hit_id       = acc.ofs == cfg[cps_video_pkg::CFG_ID_ADDR][5:1];
    assign hit_mult1    = acc.ofs == cfg[cps_video_pkg::CFG_MULT1][5:1];
    assign hit_mult2    = acc.ofs == cfg[cps_video_pkg::CFG_MULT2][5:1];
    assign hit_rslt0    = acc.ofs == cfg[cps_video_pkg::CFG_RSLT0][5:1];
    assign hit_rslt1    = acc.ofs == cfg[cps_video_pkg::CFG_RSLT1][5:1];
    assign hit_layer    = acc.ofs == cfg[cps_video_pkg::CFG_LAYER][5:1];
    assign hit_prio0    = acc.ofs == cfg[cps_video_pkg::CFG_PRIO0][5:1];
    assign hit_prio1    = acc.ofs == cfg[cps_video_pkg::CFG_PRIO1][5:1];
    assign hit_prio2    = acc.ofs == cfg[cps_video_pkg::CFG_PRIO2][5:1];
    assign hit_prio3    = acc.ofs == cfg[cps_video_pkg::CFG_PRIO3][5:1];
    assign hit_pal_page = acc.ofs == cfg[cps_video_pkg::CFG_PAL_PAGE][5:1];

    assign id_byte = cfg[cps_video_pkg::CFG_ID_VALUE];
    assign product = mult1 * mult2;
    assign wr_word = acc.valid && acc.wr && (acc.dsn == 2'b00);
    assign rd_req  = acc.valid && !acc.wr;

    always_comb begin
        rd_mux = cps_video_pkg::NO_DATA;
        // offset 31 never answers, even when a slot points at it
        if (!(&acc.ofs)) begin
            if (hit_id)
                rd_mux = {4'd0, id_byte[7:4], 4'd0, id_byte[3:0]};
            else if (hit_mult1)
                rd_mux = mult1;
            else if (hit_mult2)
                rd_mux = mult2;
            else if (hit_rslt0)
                rd_mux = product[15:0];
            else if (hit_rslt1)
                rd_mux = product[31:16];
            else if (hit_layer)
                rd_mux = layer_ctrl;
            else if (hit_prio0)
                rd_mux = prio0;
            else if (hit_prio1)
                rd_mux = prio1;
            else if (hit_prio2)
                rd_mux = prio2;
            else if (hit_prio3)
                rd_mux = prio3;
            else if (hit_pal_page)
                rd_mux = {10'd0, pal_page_en};
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1       <= '0;
            mult2       <= '0;
            layer_ctrl  <= cps_video_pkg::LAYER_CTRL_RESET;
            prio0       <= '1;
            prio1       <= '1;
            prio2       <= '1;
            prio3       <= '1;
            pal_page_en <= '1;
            rd_valid    <= 1'b0;
            rd_data     <= cps_video_pkg::NO_DATA;
        end else begin
            rd_valid <= rd_req;
            if (rd_req) begin
                rd_data <= rd_mux;
            end
            // only full-word writes land here
            if (wr_word) begin
                if (hit_mult1) mult1 <= acc.data;
                if (hit_mult2) mult2 <= acc.data;
                if (hit_layer) layer_ctrl <= acc.data;
                if (hit_prio0) prio0 <= acc.data;
                if (hit_prio1) prio1 <= acc.data;
                if (hit_prio2) prio2 <= acc.data;
                if (hit_prio3) prio3 <= acc.data;
                if (hit_pal_page) pal_page_en <= acc.data[5:0];
            end
        end
    end

    assign live = '{
        layer_ctrl:  layer_ctrl,
        prio0:       prio0,
        prio1:       prio1,
        prio2:       prio2,
        prio3:       prio3,
        pal_page_en: pal_page_en,
        layer_mask0: cfg[cps_video_pkg::CFG_MASK0],
        layer_mask1: cfg[cps_video_pkg::CFG_MASK1],
        layer_mask2: cfg[cps_video_pkg::CFG_MASK2],
        layer_mask3: cfg[cps_video_pkg::CFG_MASK3]
    };

    cfg_quiet: assert property (@(posedge clk) disable iff (reg_rst)
        !(cfg_we && acc.valid))
        else $error("configuration download overlaps a register access");

endmodule

// ==== logic/cps_frame_latch.sv ====
`timescale 1ns/1ns

module cps_frame_latch (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      frame_start,
    input  cps_video_pkg::a_regs_t    a_live,
    input  cps_video_pkg::b_regs_t    b_live,
    output cps_video_pkg::frame_cfg_t frame_cfg,
    output logic                      frame_valid
);

    logic [3:0][1:0] order_dec;

    // draw position p comes from layer_ctrl bits 7+2p:6+2p
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            order_dec[p] = b_live.layer_ctrl[6 + 2*p +: 2];
        end
    end

    // the renderer only ever sees what was live at frame start
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            frame_cfg   <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_start;
            if (frame_start) begin
                frame_cfg.a          <= a_live;
                frame_cfg.b          <= b_live;
                frame_cfg.draw_order <= order_dec;
                frame_cfg.layer_en   <= b_live.layer_ctrl[4:1];
            end
        end
    end

endmodule

// ==== logic/cps_video_regs.sv ====
`timescale 1ns/1ns

module cps_video_regs (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  cps_bus_pkg::bus_req_t     bus_req,
    input  logic                      cfg_we,
    input  logic [7:0]                cfg_data,
    input  logic                      frame_start,
    output logic                      rd_valid,
    output logic [15:0]               rd_data,
    output logic                      pal_copy,
    output cps_video_pkg::frame_cfg_t frame_cfg,
    output logic                      frame_valid
);

    cps_bus_pkg::reg_access_t a_acc;
    cps_bus_pkg::reg_access_t b_acc;
    cps_video_pkg::a_regs_t   a_live;
    cps_video_pkg::b_regs_t   b_live;

    cps_bus_decode bus_decode_i (
        .clk     (clk),
        .reg_rst (reg_rst),
        .bus_req (bus_req),
        .a_acc   (a_acc),
        .b_acc   (b_acc)
    );

    // fixed map, write only
    cps_a_regs a_regs_i (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .acc      (a_acc),
        .live     (a_live),
        .pal_copy (pal_copy)
    );

    // addresses set by the game configuration
    cps_b_regs b_regs_i (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .acc      (b_acc),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .live     (b_live),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    cps_frame_latch frame_latch_i (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .frame_start (frame_start),
        .a_live      (a_live),
        .b_live      (b_live),
        .frame_cfg   (frame_cfg),
        .frame_valid (frame_valid)
    );

endmodule

// ==== sim/cps_clock_gen.sv ====
`timescale 1ns/1ns

module cps_clock_gen (
    output logic clk,
    output logic reg_rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first three rising edges
    initial begin
        reg_rst = 1'b1;
        repeat (3) @(posedge clk);
        reg_rst <= 1'b0;
    end

endmodule

// ==== sim/tb_cps_video_regs.sv ====
`timescale 1ns/1ns

module tb_cps_video_regs;

    logic                      clk;
    logic                      reg_rst;
    cps_bus_pkg::bus_req_t     bus_req;
    logic                      cfg_we;
    logic [7:0]                cfg_data;
    logic                      frame_start;
    logic                      rd_valid;
    logic [15:0]               rd_data;
    logic                      pal_copy;
    cps_video_pkg::frame_cfg_t frame_cfg;
    logic                      frame_valid;

    // reference model state
    logic [15:0] a_mem [32];
    logic [7:0]  cfg_m [16];
    logic [15:0] m_mult1;
    logic [15:0] m_mult2;
    logic [15:0] m_layer;
    logic [15:0] m_prio [4];
    logic [5:0]  m_pal;
    logic [4:0]  spare_ofs;

    // expected responses tagged with the cycle each is due in
    int unsigned               rd_cyc_q [$];
    logic [15:0]               rd_data_q [$];
    int unsigned               pal_cyc_q [$];
    int unsigned               frame_cyc_q [$];
    cps_video_pkg::frame_cfg_t frame_q [$];

    int unsigned cyc = 0;
    int          errors = 0;
    int          timeouts = 0;

    cps_clock_gen clock_gen_i (
        .clk     (clk),
        .reg_rst (reg_rst)
    );

    cps_video_regs cps_video_regs_i (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .bus_req     (bus_req),
        .cfg_we      (cfg_we),
        .cfg_data    (cfg_data),
        .frame_start (frame_start),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .pal_copy    (pal_copy),
        .frame_cfg   (frame_cfg),
        .frame_valid (frame_valid)
    );

    function automatic logic [4:0] slot_ofs(input logic [3:0] slot);
        return cfg_m[slot][5:1];
    endfunction

    function automatic logic slot_hit(input logic [3:0] slot, input logic [4:0] ofs);
        return ofs == slot_ofs(slot);
    endfunction

    // expected read data of the configurable window
    function automatic logic [15:0] read_ref(input logic [4:0] ofs);
        logic [31:0] prod;
        prod = {16'd0, m_mult1} * {16'd0, m_mult2};
        if (ofs == 5'd31)
            return cps_video_pkg::NO_DATA;
        if (slot_hit(cps_video_pkg::CFG_ID_ADDR, ofs))
            return {4'd0, cfg_m[cps_video_pkg::CFG_ID_VALUE][7:4],
                    4'd0, cfg_m[cps_video_pkg::CFG_ID_VALUE][3:0]};
        if (slot_hit(cps_video_pkg::CFG_MULT1, ofs))
            return m_mult1;
        if (slot_hit(cps_video_pkg::CFG_MULT2, ofs))
            return m_mult2;
        if (slot_hit(cps_video_pkg::CFG_RSLT0, ofs))
            return prod[15:0];
        if (slot_hit(cps_video_pkg::CFG_RSLT1, ofs))
            return prod[31:16];
        if (slot_hit(cps_video_pkg::CFG_LAYER, ofs))
            return m_layer;
        if (slot_hit(cps_video_pkg::CFG_PRIO0, ofs))
            return m_prio[0];
        if (slot_hit(cps_video_pkg::CFG_PRIO1, ofs))
            return m_prio[1];
        if (slot_hit(cps_video_pkg::CFG_PRIO2, ofs))
            return m_prio[2];
        if (slot_hit(cps_video_pkg::CFG_PRIO3, ofs))
            return m_prio[3];
        if (slot_hit(cps_video_pkg::CFG_PAL_PAGE, ofs))
            return {10'd0, m_pal};
        return cps_video_pkg::NO_DATA;
    endfunction

    // expected snapshot for a frame start issued now
    function automatic cps_video_pkg::frame_cfg_t frame_ref();
        cps_video_pkg::frame_cfg_t f;
        f = '0;
        // words 0 to 11 fill a_regs_t in map order from its top bit down
        for (int i = 0; i < 12; i++)
            f.a[207 - 16*i -: 16] = a_mem[i];
        f.a.ppu_ctrl      = a_mem[cps_video_pkg::A_OFS_PPU_CTRL];
        f.b.layer_ctrl    = m_layer;
        f.b.prio0         = m_prio[0];
        f.b.prio1         = m_prio[1];
        f.b.prio2         = m_prio[2];
        f.b.prio3         = m_prio[3];
        f.b.pal_page_en   = m_pal;
        f.b.layer_mask0   = cfg_m[cps_video_pkg::CFG_MASK0];
        f.b.layer_mask1   = cfg_m[cps_video_pkg::CFG_MASK1];
        f.b.layer_mask2   = cfg_m[cps_video_pkg::CFG_MASK2];
        f.b.layer_mask3   = cfg_m[cps_video_pkg::CFG_MASK3];
        for (int p = 0; p < 4; p++)
            f.draw_order[p] = m_layer[6 + 2*p +: 2];
        f.layer_en = m_layer[4:1];
        return f;
    endfunction

    task automatic model_reset();
        foreach (a_mem[i])
            a_mem[i] = '0;
        // the string powers up cleared
        foreach (cfg_m[i])
            cfg_m[i] = '0;
        foreach (m_prio[i])
            m_prio[i] = '1;
        m_mult1 = '0;
        m_mult2 = '0;
        m_layer = cps_video_pkg::LAYER_CTRL_RESET;
        m_pal   = '1;
    endtask

    // one bus strobe followed by at least one idle cycle
    task automatic bus_access(input logic wr, input logic win, input logic [4:0] ofs,
                              input logic [1:0] dsn, input logic [15:0] data);
        int unsigned s;
        @(posedge clk);
        bus_req <= '{wr: wr, rd: !wr, addr: {win, ofs}, dsn: dsn, data: data};
        // cyc still holds the count from before this edge
        s = cyc + 1;
        if (!wr && win) begin
            rd_cyc_q.push_back(s + 2);
            rd_data_q.push_back(read_ref(ofs));
        end else if (wr && !win) begin
            if (ofs <= 5'd11 || ofs == cps_video_pkg::A_OFS_PPU_CTRL) begin
                if (!dsn[1])
                    a_mem[ofs][15:8] = data[15:8];
                if (!dsn[0])
                    a_mem[ofs][7:0] = data[7:0];
            end
            if (ofs == cps_video_pkg::A_OFS_PAL_BASE)
                pal_cyc_q.push_back(s + 3);
        end else if (wr && dsn == 2'b00) begin
            if (slot_hit(cps_video_pkg::CFG_MULT1, ofs))
                m_mult1 = data;
            if (slot_hit(cps_video_pkg::CFG_MULT2, ofs))
                m_mult2 = data;
            if (slot_hit(cps_video_pkg::CFG_LAYER, ofs))
                m_layer = data;
            for (int i = 0; i < 4; i++)
                if (slot_hit(4'(cps_video_pkg::CFG_PRIO0 + i), ofs))
                    m_prio[i] = data;
            if (slot_hit(cps_video_pkg::CFG_PAL_PAGE, ofs))
                m_pal = data[5:0];
        end
        @(posedge clk);
        bus_req <= '0;
        repeat ($urandom_range(0, 2)) @(posedge clk);
    endtask

    task automatic frame_snap();
        @(posedge clk);
        frame_start <= 1'b1;
        frame_cyc_q.push_back(cyc + 2);
        frame_q.push_back(frame_ref());
        @(posedge clk);
        frame_start <= 1'b0;
    endtask

    // sends the model string so that its first byte lands in slot 15
    task automatic shift_cfg();
        for (int k = 15; k >= 0; k--) begin
            @(posedge clk);
            cfg_we   <= 1'b1;
            cfg_data <= cfg_m[k];
        end
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    // random string with distinct word offsets below 31 in the eleven address slots
    task automatic load_cfg();
        logic [4:0] pool [31];
        logic [4:0] tmp;
        int         j;
        for (int i = 0; i < 31; i++)
            pool[i] = 5'(i);
        for (int i = 30; i > 0; i--) begin
            j       = $urandom_range(0, i);
            tmp     = pool[i];
            pool[i] = pool[j];
            pool[j] = tmp;
        end
        for (int k = 0; k < 16; k++)
            cfg_m[k] = 8'($urandom);
        cfg_m[cps_video_pkg::CFG_ID_ADDR] = {2'b00, pool[0], 1'($urandom)};
        for (int k = 2; k < 12; k++)
            cfg_m[k] = {2'b00, pool[k - 1], 1'($urandom)};
        spare_ofs = pool[11];
        shift_cfg();
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (rd_cyc_q.size() + pal_cyc_q.size() + frame_cyc_q.size() > 0 && n < 40) begin
            @(posedge clk);
            n++;
        end
        assert (rd_cyc_q.size() + pal_cyc_q.size() + frame_cyc_q.size() == 0) else begin
            timeouts++;
            $display("timed out waiting for the %s responses", what);
            rd_cyc_q.delete();
            rd_data_q.delete();
            pal_cyc_q.delete();
            frame_cyc_q.delete();
            frame_q.delete();
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are compared at the falling edge in mid-cycle
    always @(negedge clk) begin
        if (!reg_rst) begin
            if (rd_valid) begin
                assert (rd_cyc_q.size() > 0 && rd_cyc_q[0] == cyc
                        && rd_data_q[0] == rd_data) else begin
                    errors++;
                    $display("error at %0t: read gave %h in cycle %0d, expected %h", $time,
                             rd_data, cyc, (rd_data_q.size() > 0) ? rd_data_q[0] : 16'hxxxx);
                end
                if (rd_cyc_q.size() > 0) begin
                    void'(rd_cyc_q.pop_front());
                    void'(rd_data_q.pop_front());
                end
            end
            if (pal_copy) begin
                assert (pal_cyc_q.size() > 0 && pal_cyc_q[0] == cyc) else begin
                    errors++;
                    $display("error at %0t: pal_copy pulse in cycle %0d not expected",
                             $time, cyc);
                end
                if (pal_cyc_q.size() > 0)
                    void'(pal_cyc_q.pop_front());
            end
            if (frame_valid) begin
                assert (frame_cyc_q.size() > 0 && frame_cyc_q[0] == cyc
                        && frame_q[0] == frame_cfg) else begin
                    errors++;
                    $display("error at %0t: frame snapshot in cycle %0d differs from model",
                             $time, cyc);
                end
                if (frame_cyc_q.size() > 0) begin
                    void'(frame_cyc_q.pop_front());
                    void'(frame_q.pop_front());
                end
            end
        end
    end

    initial begin
        int          n;
        logic [4:0]  ofs;
        logic [1:0]  dsn;
        logic        wr;
        bus_req     = '0;
        cfg_we      = 1'b0;
        cfg_data    = '0;
        frame_start = 1'b0;
        void'($urandom(32'h0d7556a7));
        model_reset();

        @(posedge clk);
        n = 0;
        while (reg_rst && n < 20) begin
            @(posedge clk);
            n++;
        end
        assert (!reg_rst) else begin
            timeouts++;
            $display("reset was never released");
        end
        @(negedge clk);
        assert (!rd_valid && !pal_copy && !frame_valid && rd_data == cps_video_pkg::NO_DATA
                && frame_cfg == '0) else begin
            errors++;
            $display("error at %0t: outputs not at their reset values", $time);
        end

        // snapshot of the reset state
        frame_snap();
        wait_drained("reset snapshot");
        @(negedge clk);
        // position 0 draws layer 3 and all four layers are on
        assert (frame_cfg.draw_order == {2'd0, 2'd1, 2'd2, 2'd3}
                && frame_cfg.layer_en == 4'b1111) else begin
            errors++;
            $display("error at %0t: reset draw order %h with enables %b, expected 1b and 1111",
                     $time, frame_cfg.draw_order, frame_cfg.layer_en);
        end

        repeat (40) begin
            bus_access(1'b1, 1'b0, 5'($urandom_range(0, 31)), 2'($urandom), 16'($urandom));
        end
        frame_snap();
        wait_drained("fixed window");

        // fixed-window reads in between must stay silent
        repeat (8) begin
            bus_access(1'b1, 1'b0, cps_video_pkg::A_OFS_PAL_BASE, 2'($urandom), 16'($urandom));
            bus_access(1'b0, 1'b0, 5'($urandom_range(0, 31)), 2'b00, 16'h0000);
        end
        repeat (4) @(posedge clk);
        wait_drained("palette copy");

        load_cfg();
        repeat (60) begin
            if ($urandom_range(0, 3) != 0)
                ofs = slot_ofs(4'($urandom_range(0, 11)));
            else
                ofs = 5'($urandom);
            wr  = 1'($urandom);
            dsn = ($urandom_range(0, 3) == 0) ? 2'($urandom) : 2'b00;
            bus_access(wr, 1'b1, ofs, dsn, 16'($urandom));
        end
        bus_access(1'b0, 1'b1, slot_ofs(cps_video_pkg::CFG_ID_ADDR), 2'b00, 16'h0000);
        bus_access(1'b0, 1'b1, spare_ofs, 2'b00, 16'h0000);
        bus_access(1'b0, 1'b1, 5'd31, 2'b00, 16'h0000);
        wait_drained("configured window");

        repeat (6) begin
            bus_access(1'b1, 1'b1, slot_ofs(cps_video_pkg::CFG_MULT1), 2'b00, 16'($urandom));
            bus_access(1'b1, 1'b1, slot_ofs(cps_video_pkg::CFG_MULT2), 2'b00, 16'($urandom));
            bus_access(1'b0, 1'b1, slot_ofs(cps_video_pkg::CFG_RSLT0), 2'b00, 16'h0000);
            bus_access(1'b0, 1'b1, slot_ofs(cps_video_pkg::CFG_RSLT1), 2'b00, 16'h0000);
        end
        wait_drained("multiplier");

        repeat (6) begin
            bus_access(1'b1, 1'b1, slot_ofs(cps_video_pkg::CFG_LAYER), 2'b00, 16'($urandom));
            frame_snap();
        end
        wait_drained("layer control");

        // the ID address moved onto word 31 still reads as no data
        cfg_m[cps_video_pkg::CFG_ID_ADDR] = 8'h3e;
        shift_cfg();
        bus_access(1'b0, 1'b1, 5'd31, 2'b00, 16'h0000);
        wait_drained("offset 31");

        $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/cps_bus_pkg.sv
logic/cps_video_pkg.sv
logic/cps_bus_decode.sv
logic/cps_a_regs.sv
logic/cps_b_regs.sv
logic/cps_frame_latch.sv
logic/cps_video_regs.sv
sim/cps_clock_gen.sv
sim/tb_cps_video_regs.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP      = tb_cps_video_regs
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Finished with errors
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
